/* design/wb_bus_pkg.sv */
// Wishbone slave side definitions for the SDRAM bridge
// Word address, data and byte-lane widths with their vector types

package wb_bus_pkg;

  // -------------------------------------------------------------------
  // Bus widths
  // -------------------------------------------------------------------

  // Word address, byte offset already stripped by the master
  localparam int WB_ADDR_W = 30;

  // Data bus width in bits
  localparam int WB_DATA_W = 32;

  // One select bit per byte lane
  localparam int WB_SEL_W  = WB_DATA_W / 8;

  // -------------------------------------------------------------------
  // Vector types
  // -------------------------------------------------------------------

  // Word address as driven on wb_addr_i
  typedef logic [WB_ADDR_W-1:0] wb_addr_t;

  // Read or write data word
  typedef logic [WB_DATA_W-1:0] wb_data_t;

  // Byte lanes
  // Active high when used as a Wishbone select
  // Active low when used as an SDRAM write mask
  typedef logic [WB_SEL_W-1:0] wb_sel_t;

endpackage

/* design/sdr_ctrl_pkg.sv */
// SDRAM controller side definitions for the Wishbone bridge
// Request and write-data queue entries plus the queue depths

package sdr_ctrl_pkg;

  // -------------------------------------------------------------------
  // Queue depths
  // -------------------------------------------------------------------

  // Requests waiting for sdr_req_ack
  localparam int CMD_FIFO_DEPTH   = 4;

  // Write beats waiting for sdr_wr_next
  localparam int WDATA_FIFO_DEPTH = 8;

  // Returned read words
  // Only one read in flight, so this never fills
  localparam int RDATA_FIFO_DEPTH = 4;

  // -------------------------------------------------------------------
  // Queue entries
  // -------------------------------------------------------------------

  // Request command, always a single transfer
  typedef struct packed {
    // Low for write, high for read
    logic                 wr_n;
    // Word address of the transfer
    wb_bus_pkg::wb_addr_t addr;
  } sdr_cmd_t;

  // One write beat with its byte mask
  typedef struct packed {
    // Active low byte write enables
    wb_bus_pkg::wb_sel_t  wr_en_n;
    wb_bus_pkg::wb_data_t data;
  } sdr_wdata_t;

endpackage

/* design/sync_fifo.sv */
// Synchronous first-word-fall-through queue
// Head entry shows on pop_data_o whenever the queue holds data

`timescale 1ns/1ps

module sync_fifo #(
  parameter int WIDTH = 8,
  parameter int DEPTH = 4
) (
  // Clock and asynchronous active-high reset
  input  logic             sdram_clk,
  input  logic             wb_clk_i,
  // Producer side
  input  logic             push_i,
  input  logic [WIDTH-1:0] push_data_i,
  // Consumer side
  input  logic             pop_i,
  // Status flags
  output logic             full_o,
  output logic             empty_o,
  // Current head entry
  output logic [WIDTH-1:0] pop_data_o
);

  // Pointer and occupancy types sized from the depth
  typedef logic [$clog2(DEPTH)-1:0]   ptr_t;
  typedef logic [$clog2(DEPTH+1)-1:0] cnt_t;

  // Entry storage
  logic [WIDTH-1:0] mem [DEPTH];

  // Next slot to write and current head
  ptr_t wr_ptr;
  ptr_t rd_ptr;

  // Number of valid entries
  cnt_t count;

  // Step a pointer and wrap after the last slot
  // Works for depths that are not a power of two
  function automatic ptr_t ptr_inc(input ptr_t ptr);
    ptr_t nxt;
    if (ptr == ptr_t'(DEPTH - 1)) begin
      nxt = '0;
    end else begin
      nxt = ptr + 1'b1;
    end
    return nxt;
  endfunction

  // -------------------------------------------------------------------
  // Storage write
  // -------------------------------------------------------------------
  always_ff @(posedge sdram_clk) begin
    if (push_i) begin
      mem[wr_ptr] <= push_data_i;
    end
  end

  // -------------------------------------------------------------------
  // Pointers and occupancy
  // -------------------------------------------------------------------
  always_ff @(posedge sdram_clk or posedge wb_clk_i) begin
    if (wb_clk_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (push_i) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      // Head moves on in the cycle after the pop
      if (pop_i) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
    end
  end

  always_ff @(posedge sdram_clk or posedge wb_clk_i) begin
    if (wb_clk_i) begin
      count <= '0;
    end else begin
      case ({push_i, pop_i})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        // Push with pop, or idle
        default: count <= count;
      endcase
    end
  end

  // Flags straight from the count
  assign full_o     = (count == cnt_t'(DEPTH));
  assign empty_o    = (count == '0);

  // Fall-through head word
  assign pop_data_o = mem[rd_ptr];

endmodule

/* design/wb_req_decode.sv */
// Wishbone request decoder for the SDRAM bridge
// Turns each bus cycle into queue pushes and generates the acknowledge

`timescale 1ns/1ps

module wb_req_decode (
  // Clock and asynchronous active-high reset
  input  logic                     sdram_clk,
  input  logic                     wb_clk_i,
  // Wishbone slave port
  input  logic                     wb_stb_i,
  input  logic                     wb_cyc_i,
  input  logic                     wb_we_i,
  input  wb_bus_pkg::wb_addr_t     wb_addr_i,
  input  wb_bus_pkg::wb_data_t     wb_dat_i,
  input  wb_bus_pkg::wb_sel_t      wb_sel_i,
  output logic                     wb_ack_o,
  // Queue status
  input  logic                     cmd_full_i,
  input  logic                     wdata_full_i,
  input  logic                     rdata_empty_i,
  // Command queue push
  output logic                     cmd_push_o,
  output sdr_ctrl_pkg::sdr_cmd_t   cmd_o,
  // Write-data queue push
  output logic                     wdata_push_o,
  output sdr_ctrl_pkg::sdr_wdata_t wdata_o,
  // Read-data queue pop
  output logic                     rdata_pop_o
);

  import wb_bus_pkg::*;
  import sdr_ctrl_pkg::*;

  // Pending read tracking
  typedef enum logic {
    rd_idle,
    rd_wait
  } rd_state_t;

  rd_state_t rd_state;

  // Decoded request
  logic wb_req;
  logic wr_req;
  logic rd_req;

  // Acknowledge terms and read issue
  logic wr_ack;
  logic rd_ack;
  logic rd_issue;

  // Byte enables as SDRAM mask
  wb_sel_t wr_mask_n;

  // -------------------------------------------------------------------
  // Cycle decode
  // -------------------------------------------------------------------

  // Valid cycle needs both strobe and cycle
  assign wb_req = wb_stb_i & wb_cyc_i;
  assign wr_req = wb_req & wb_we_i;
  assign rd_req = wb_req & ~wb_we_i;

  // -------------------------------------------------------------------
  // Acknowledge
  // -------------------------------------------------------------------

  // Write done once both queues take it
  // Held low while either queue is full
  assign wr_ack = wr_req & ~cmd_full_i & ~wdata_full_i;

  // Read done when its data has come back
  assign rd_ack = rd_req & (rd_state == rd_wait) & ~rdata_empty_i;

  assign wb_ack_o = wr_ack | rd_ack;

  // -------------------------------------------------------------------
  // Queue control
  // -------------------------------------------------------------------

  // Only one read forwarded until its data is returned
  assign rd_issue = rd_req & (rd_state == rd_idle) & ~cmd_full_i;

  // Writes push on the acknowledge itself
  assign cmd_push_o   = wr_ack | rd_issue;
  assign wdata_push_o = wr_ack;

  // Acked read consumes the head word
  assign rdata_pop_o  = rd_ack;

  // Select is active high, controller mask active low
  assign wr_mask_n = ~wb_sel_i;

  // Queue entries built from the live bus fields
  assign cmd_o   = sdr_cmd_t'{wr_n: ~wb_we_i, addr: wb_addr_i};
  assign wdata_o = sdr_wdata_t'{wr_en_n: wr_mask_n, data: wb_dat_i};

  // -------------------------------------------------------------------
  // Pending read FSM
  // -------------------------------------------------------------------
  always_ff @(posedge sdram_clk or posedge wb_clk_i) begin
    if (wb_clk_i) begin
      rd_state <= rd_idle;
    end else begin
      case (rd_state)
        rd_idle: begin
          // Read command queued, wait for its data
          if (rd_issue) begin
            rd_state <= rd_wait;
          end
        end
        rd_wait: begin
          if (rd_ack) begin
            rd_state <= rd_idle;
          end
        end
        default: rd_state <= rd_idle;
      endcase
    end
  end

endmodule

/* design/wb2sdrc_top.sv */
// Wishbone to SDRAM controller bridge, single clock domain
// Decoder feeding command and write-data queues, read data queued back

`timescale 1ns/1ps

module wb2sdrc_top (
  // Clock and asynchronous active-high reset
  input  logic                 sdram_clk,
  input  logic                 wb_clk_i,
  // Wishbone slave port
  input  logic                 wb_stb_i,
  input  logic                 wb_cyc_i,
  input  logic                 wb_we_i,
  input  wb_bus_pkg::wb_addr_t wb_addr_i,
  input  wb_bus_pkg::wb_data_t wb_dat_i,
  input  wb_bus_pkg::wb_sel_t  wb_sel_i,
  output logic                 wb_ack_o,
  output wb_bus_pkg::wb_data_t wb_dat_o,
  // SDRAM controller request handshake
  output logic                 sdr_req_o,
  output wb_bus_pkg::wb_addr_t sdr_req_addr_o,
  output logic                 sdr_req_wr_n_o,
  input  logic                 sdr_req_ack_i,
  // Write data path
  output wb_bus_pkg::wb_sel_t  sdr_wr_en_n_o,
  output wb_bus_pkg::wb_data_t sdr_wr_data_o,
  input  logic                 sdr_wr_next_i,
  // Read data path
  input  logic                 sdr_rd_valid_i,
  input  wb_bus_pkg::wb_data_t sdr_rd_data_i
);

  import wb_bus_pkg::*;
  import sdr_ctrl_pkg::*;

  // Command queue
  logic       cmd_push;
  logic       cmd_full;
  logic       cmd_empty;
  sdr_cmd_t   cmd_in;
  sdr_cmd_t   cmd_head;

  // Write-data queue
  logic       wdata_push;
  logic       wdata_full;
  sdr_wdata_t wdata_in;
  sdr_wdata_t wdata_head;

  // Read-data queue
  logic       rdata_pop;
  logic       rdata_empty;

  // -------------------------------------------------------------------
  // Request decoder
  // -------------------------------------------------------------------
  wb_req_decode u_decode (
    .sdram_clk     (sdram_clk),
    .wb_clk_i      (wb_clk_i),
    .wb_stb_i      (wb_stb_i),
    .wb_cyc_i      (wb_cyc_i),
    .wb_we_i       (wb_we_i),
    .wb_addr_i     (wb_addr_i),
    .wb_dat_i      (wb_dat_i),
    .wb_sel_i      (wb_sel_i),
    .wb_ack_o      (wb_ack_o),
    .cmd_full_i    (cmd_full),
    .wdata_full_i  (wdata_full),
    .rdata_empty_i (rdata_empty),
    .cmd_push_o    (cmd_push),
    .cmd_o         (cmd_in),
    .wdata_push_o  (wdata_push),
    .wdata_o       (wdata_in),
    .rdata_pop_o   (rdata_pop)
  );

  // -------------------------------------------------------------------
  // Command queue, popped by the controller acknowledge
  // -------------------------------------------------------------------
  sync_fifo #(
    .WIDTH ($bits(sdr_cmd_t)),
    .DEPTH (CMD_FIFO_DEPTH)
  ) u_cmd_fifo (
    .sdram_clk   (sdram_clk),
    .wb_clk_i    (wb_clk_i),
    .push_i      (cmd_push),
    .push_data_i (cmd_in),
    .pop_i       (sdr_req_ack_i),
    .full_o      (cmd_full),
    .empty_o     (cmd_empty),
    .pop_data_o  (cmd_head)
  );

  // Request held while any command waits
  assign sdr_req_o      = ~cmd_empty;
  assign sdr_req_addr_o = cmd_head.addr;
  assign sdr_req_wr_n_o = cmd_head.wr_n;

  // -------------------------------------------------------------------
  // Write-data queue, one beat per sdr_wr_next
  // -------------------------------------------------------------------
  sync_fifo #(
    .WIDTH ($bits(sdr_wdata_t)),
    .DEPTH (WDATA_FIFO_DEPTH)
  ) u_wdata_fifo (
    .sdram_clk   (sdram_clk),
    .wb_clk_i    (wb_clk_i),
    .push_i      (wdata_push),
    .push_data_i (wdata_in),
    .pop_i       (sdr_wr_next_i),
    .full_o      (wdata_full),
    .empty_o     (),
    .pop_data_o  (wdata_head)
  );

  assign sdr_wr_en_n_o = wdata_head.wr_en_n;
  assign sdr_wr_data_o = wdata_head.data;

  // -------------------------------------------------------------------
  // Read-data queue
  // -------------------------------------------------------------------
  // Full flag unused, a single outstanding read cannot fill it
  sync_fifo #(
    .WIDTH ($bits(wb_data_t)),
    .DEPTH (RDATA_FIFO_DEPTH)
  ) u_rdata_fifo (
    .sdram_clk   (sdram_clk),
    .wb_clk_i    (wb_clk_i),
    .push_i      (sdr_rd_valid_i),
    .push_data_i (sdr_rd_data_i),
    .pop_i       (rdata_pop),
    .full_o      (),
    .empty_o     (rdata_empty),
    .pop_data_o  (wb_dat_o)
  );

endmodule

/* bench/tb_wb2sdrc.sv */
// Testbench for the Wishbone to SDRAM controller bridge
// File-driven Wishbone master, SDRAM controller model and result checks

`timescale 1ns/1ps

module tb_wb2sdrc;

  import wb_bus_pkg::*;
  import sdr_ctrl_pkg::*;

  localparam int CLK_HALF     = 5;
  // Sample point after the falling edge
  localparam int SETTLE       = 2;
  localparam int STALL_CYCLES = 20;
  localparam int MEM_WORDS    = 256;

  // One line of the vector file
  typedef struct packed {
    logic     we;
    wb_addr_t addr;
    wb_data_t data;
    wb_sel_t  sel;
    wb_data_t exp_data;
  } vec_t;

  // Command as the controller should see it
  typedef struct packed {
    logic     wr_n;
    wb_addr_t addr;
    wb_sel_t  mask_n;
    wb_data_t data;
  } ctrl_cmd_t;

  // DUT ports
  logic     sdram_clk;
  logic     wb_clk_i;
  logic     wb_stb_i;
  logic     wb_cyc_i;
  logic     wb_we_i;
  wb_addr_t wb_addr_i;
  wb_data_t wb_dat_i;
  wb_sel_t  wb_sel_i;
  logic     wb_ack_o;
  wb_data_t wb_dat_o;
  logic     sdr_req_o;
  wb_addr_t sdr_req_addr_o;
  logic     sdr_req_wr_n_o;
  logic     sdr_req_ack_i;
  wb_sel_t  sdr_wr_en_n_o;
  wb_data_t sdr_wr_data_o;
  logic     sdr_wr_next_i;
  logic     sdr_rd_valid_i;
  wb_data_t sdr_rd_data_i;

  // Vectors and expected controller commands
  string       names[$];
  vec_t        vecs[$];
  ctrl_cmd_t   exp_cmds[$];
  string       cur_name = "reset_idle";

  // Result bookkeeping
  // Model errors are counted on their own
  int          errors       = 0;
  int          model_errors = 0;
  int          tests_passed = 0;
  int          tests_failed = 0;
  int          read_acks    = 0;
  int          model_reads  = 0;
  int          rd_returns   = 0;
  int          stall_reqs   = 0;
  int          cycles       = 0;
  int          cycle_limit  = 100000;

  // Controller memory and delay generator
  wb_data_t    mem [MEM_WORDS];
  logic [31:0] lcg_state    = 32'd60;

  wb2sdrc_top DUT (
    .sdram_clk      (sdram_clk),
    .wb_clk_i       (wb_clk_i),
    .wb_stb_i       (wb_stb_i),
    .wb_cyc_i       (wb_cyc_i),
    .wb_we_i        (wb_we_i),
    .wb_addr_i      (wb_addr_i),
    .wb_dat_i       (wb_dat_i),
    .wb_sel_i       (wb_sel_i),
    .wb_ack_o       (wb_ack_o),
    .wb_dat_o       (wb_dat_o),
    .sdr_req_o      (sdr_req_o),
    .sdr_req_addr_o (sdr_req_addr_o),
    .sdr_req_wr_n_o (sdr_req_wr_n_o),
    .sdr_req_ack_i  (sdr_req_ack_i),
    .sdr_wr_en_n_o  (sdr_wr_en_n_o),
    .sdr_wr_data_o  (sdr_wr_data_o),
    .sdr_wr_next_i  (sdr_wr_next_i),
    .sdr_rd_valid_i (sdr_rd_valid_i),
    .sdr_rd_data_i  (sdr_rd_data_i)
  );

  // Linear congruential generator
  // Returns the upper bits only
  function automatic int unsigned lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return {17'd0, lcg_state[30:16]};
  endfunction

  // -------------------------------------------------------------------
  // Helpers
  // -------------------------------------------------------------------

  // Reads the vector file, skipping comments and blank lines
  task automatic load_vectors();
    int          fd;
    int          n;
    string       line;
    string       name;
    string       op;
    logic [31:0] a;
    logic [31:0] d;
    logic [31:0] s;
    logic [31:0] e;
    vec_t        v;
    fd = $fopen("bench/wb2sdrc_input.txt", "r");
    assert (fd != 0) else begin
      $display("Could not open bench/wb2sdrc_input.txt for reading");
      errors++;
    end
    if (fd != 0) begin
      while ($fgets(line, fd) != 0) begin
        if (line.len() < 2 || line.getc(0) == "#") begin
          continue;
        end
        n = $sscanf(line, "%s %s %h %h %h %h", name, op, a, d, s, e);
        assert (n == 6) else begin
          $display("Vector line could not be parsed: %s", line);
          errors++;
        end
        if (n != 6) begin
          continue;
        end
        v.we       = (op == "W");
        v.addr     = a[WB_ADDR_W-1:0];
        v.data     = d;
        v.sel      = s[WB_SEL_W-1:0];
        v.exp_data = e;
        vecs.push_back(v);
        names.push_back(name);
      end
      $fclose(fd);
    end
    assert (vecs.size() != 0) else begin
      $display("No test vectors were found in bench/wb2sdrc_input.txt");
      errors++;
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    if (errors + model_errors == errs_before) begin
      tests_passed++;
      $display("PASS %s", name);
    end else begin
      tests_failed++;
      $display("FAIL %s", name);
    end
  endtask

  // One Wishbone cycle held until the acknowledge
  task automatic run_transfer(input vec_t v, output wb_data_t rdata, output int waited);
    ctrl_cmd_t c;
    logic      acked;
    c.wr_n   = ~v.we;
    c.addr   = v.addr;
    // Select is active high, controller mask active low
    c.mask_n = v.we ? ~v.sel : '0;
    c.data   = v.we ? v.data : '0;
    exp_cmds.push_back(c);
    rdata  = '0;
    waited = 0;
    acked  = 1'b0;
    @(negedge sdram_clk);
    wb_cyc_i  = 1'b1;
    wb_stb_i  = 1'b1;
    wb_we_i   = v.we;
    wb_addr_i = v.addr;
    wb_dat_i  = v.data;
    wb_sel_i  = v.sel;
    while (!acked) begin
      #SETTLE;
      if (wb_ack_o) begin
        acked = 1'b1;
        rdata = wb_dat_o;
        if (v.we) begin
          // Fewer than four commands may wait in the queue before this push
          // An ack driven in this cycle has left the list but not the queue
          assert (exp_cmds.size() + int'(sdr_req_ack_i) <= CMD_FIFO_DEPTH) else begin
            $display("%s: write acknowledged with the command queue full", cur_name);
            errors++;
          end
        end else begin
          read_acks++;
        end
      end else begin
        waited++;
      end
      @(negedge sdram_clk);
    end
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
    #SETTLE;
    assert (!wb_ack_o) else begin
      $display("%s: acknowledge still high after strobe was dropped", cur_name);
      errors++;
    end
  endtask

  // Compare a controller command with the next expected one
  task automatic check_command(input ctrl_cmd_t got);
    ctrl_cmd_t want;
    assert (exp_cmds.size() != 0) else begin
      $display("%s: controller saw a command that no request produced", cur_name);
      model_errors++;
    end
    if (exp_cmds.size() != 0) begin
      want = exp_cmds.pop_front();
      assert (got == want) else begin
        $display("ERROR %s: command expected %h, actual %h", cur_name, want, got);
        model_errors++;
      end
    end
    if (got.wr_n) begin
      // Earlier read must have been acknowledged on the bus
      assert (model_reads == read_acks) else begin
        $display("%s: second read command while a read was outstanding", cur_name);
        model_errors++;
      end
      model_reads++;
    end
  endtask

  task automatic merge_write(input wb_addr_t addr, input wb_sel_t mask_n,
                             input wb_data_t data);
    wb_data_t word;
    word = mem[addr[7:0]];
    for (int b = 0; b < WB_SEL_W; b++) begin
      if (!mask_n[b]) begin
        word[8*b +: 8] = data[8*b +: 8];
      end
    end
    mem[addr[7:0]] = word;
  endtask

  // -------------------------------------------------------------------
  // Clock, timeout and controller model
  // -------------------------------------------------------------------
  initial begin : clock_gen
    sdram_clk = 1'b0;
    forever #CLK_HALF sdram_clk = ~sdram_clk;
  end

  initial begin : watchdog
    while (cycles <= cycle_limit) begin
      @(posedge sdram_clk);
      cycles++;
    end
    $display("Timeout after %0d cycles, the bridge stopped making progress", cycles);
    $display("Simulation failed");
    $finish;
  end

  initial begin : ctrl_model
    ctrl_cmd_t   got;
    int unsigned delay;
    int          stalls_done;
    sdr_req_ack_i  = 1'b0;
    sdr_wr_next_i  = 1'b0;
    sdr_rd_valid_i = 1'b0;
    sdr_rd_data_i  = '0;
    stalls_done    = 0;
    // Fill pattern built from every address bit
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = {8'(~i), 8'(i), 8'h5A, 8'(i)};
    end
    @(negedge sdram_clk);
    while (wb_clk_i) @(negedge sdram_clk);
    forever begin
      @(negedge sdram_clk);
      if (stall_reqs != stalls_done) begin
        stalls_done++;
        repeat (STALL_CYCLES) @(negedge sdram_clk);
      end
      if (sdr_req_o) begin
        delay = lcg_next() % 8;
        repeat (delay) @(negedge sdram_clk);
        got.wr_n   = sdr_req_wr_n_o;
        got.addr   = sdr_req_addr_o;
        got.mask_n = sdr_req_wr_n_o ? '0 : sdr_wr_en_n_o;
        got.data   = sdr_req_wr_n_o ? '0 : sdr_wr_data_o;
        // Ack pops the command
        // Write beat taken in the same cycle
        sdr_req_ack_i = 1'b1;
        sdr_wr_next_i = ~sdr_req_wr_n_o;
        check_command(got);
        if (!got.wr_n) begin
          merge_write(got.addr, got.mask_n, got.data);
        end
        @(negedge sdram_clk);
        sdr_req_ack_i = 1'b0;
        sdr_wr_next_i = 1'b0;
        if (got.wr_n) begin
          delay = lcg_next() % 8;
          repeat (delay) @(negedge sdram_clk);
          sdr_rd_valid_i = 1'b1;
          sdr_rd_data_i  = mem[got.addr[7:0]];
          rd_returns++;
          @(negedge sdram_clk);
          sdr_rd_valid_i = 1'b0;
        end
      end
    end
  end

  // -------------------------------------------------------------------
  // Main sequence
  // -------------------------------------------------------------------
  initial begin : main_seq
    wb_data_t rdata;
    int       waited;
    int       errs_before;
    vec_t     v;
    wb_clk_i  = 1'b1;
    wb_stb_i  = 1'b0;
    wb_cyc_i  = 1'b0;
    wb_we_i   = 1'b0;
    wb_addr_i = '0;
    wb_dat_i  = '0;
    wb_sel_i  = '0;
    load_vectors();
    cycle_limit = vecs.size() * 40 + 100;
    repeat (4) @(negedge sdram_clk);
    wb_clk_i = 1'b0;

    // Idle outputs after reset
    @(negedge sdram_clk);
    #SETTLE;
    errs_before = errors + model_errors;
    assert (!wb_ack_o && !sdr_req_o) else begin
      $display("reset_idle: wb_ack_o or sdr_req_o high after reset");
      errors++;
    end
    report_test(cur_name, errs_before);

    foreach (vecs[i]) begin
      v           = vecs[i];
      cur_name    = names[i];
      errs_before = errors + model_errors;
      if (cur_name == "stall") begin
        stall_reqs++;
      end
      run_transfer(v, rdata, waited);
      if (!v.we) begin
        assert (rdata == v.exp_data) else begin
          $display("ERROR %s: expected %h, actual %h", cur_name, v.exp_data, rdata);
          errors++;
        end
      end
      if (cur_name == "stall_full") begin
        assert (waited > 0) else begin
          $display("%s: write was not held off by the full command queue", cur_name);
          errors++;
        end
      end
      report_test(cur_name, errs_before);
    end

    // Let the controller drain every command
    cur_name    = "drain";
    errs_before = errors + model_errors;
    while (exp_cmds.size() != 0) @(negedge sdram_clk);
    repeat (10) @(negedge sdram_clk);
    assert (rd_returns == read_acks) else begin
      $display("ERROR drain: expected %0d, actual %0d read acknowledges", rd_returns, read_acks);
      errors++;
    end
    report_test(cur_name, errs_before);

    $display("Tests: %0d passed, %0d failed", tests_passed, tests_failed);
    if (errors + model_errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* bench/wb2sdrc_input.txt */
# Columns: test name, op (W write, R read), word address, write data, byte select,
# expected read data; numbers in hex, fields a test does not use are zero or F
full_wr     W 00000010 DEADBEEF F 00000000
full_rd     R 00000010 00000000 F DEADBEEF
byte_wr     W 00000010 00000000 8 00000000
byte_rd     R 00000010 00000000 F 00ADBEEF
part_base   W 00000020 11223344 F 00000000
part_wr     W 00000020 AABBCCDD 5 00000000
part_rd     R 00000020 00000000 F 11BB33DD
part_wr2    W 00000020 99887766 A 00000000
part_rd2    R 00000020 00000000 F 99BB77DD
burst_w0    W 00000030 01234567 F 00000000
burst_w1    W 00000031 89ABCDEF F 00000000
burst_w2    W 00000032 CAFEF00D F 00000000
burst_w3    W 00000033 0BADBEEF F 00000000
burst_w4    W 00000031 FFFF0000 C 00000000
burst_r0    R 00000030 00000000 F 01234567
burst_r1    R 00000031 00000000 F FFFFCDEF
burst_r2    R 00000032 00000000 F CAFEF00D
burst_r3    R 00000033 00000000 F 0BADBEEF
mix_w       W 00000040 13572468 F 00000000
mix_r       R 00000040 00000000 F 13572468
mix_r2      R 00000030 00000000 F 01234567
stall       W 00000050 A5A5A5A5 F 00000000
stall_w1    W 00000051 5A5A5A5A F 00000000
stall_w2    W 00000052 12345678 F 00000000
stall_w3    W 00000053 87654321 F 00000000
stall_full  W 00000054 FEEDFACE F 00000000
stall_r0    R 00000050 00000000 F A5A5A5A5
stall_r1    R 00000051 00000000 F 5A5A5A5A
stall_r2    R 00000052 00000000 F 12345678
stall_r3    R 00000053 00000000 F 87654321
stall_r4    R 00000054 00000000 F FEEDFACE

/* filelist.f */
design/wb_bus_pkg.sv
design/sdr_ctrl_pkg.sv
design/sync_fifo.sv
design/wb_req_decode.sv
design/wb2sdrc_top.sv
bench/tb_wb2sdrc.sv

/* Makefile */
# Verilator simulation of the Wishbone to SDRAM controller bridge
# Override any variable on the command line, e.g. make sim OBJ_DIR=build

VERILATOR ?= verilator
TOP       ?= tb_wb2sdrc
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
PASS_MSG  ?= Simulation passed

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
